// ==== verilog/sequencer_cfg.svh ====
`ifndef SEQUENCER_CFG_SVH
`define SEQUENCER_CFG_SVH

// command FIFO size, AW is log2 of the depth
`define CMD_FIFO_DEPTH 16
`define CMD_FIFO_AW    4

// system clocks per time unit of the event timer
`define TIME_TICK_DIV  4

// upper address byte that the pin control unit answers to
`define PIN_UNIT_ID    8'h21

// command word layout
// time in the top 32 bits, then bus data, bus address at the bottom
`define CMD_TIME_H     79
`define CMD_TIME_L     48
`define CMD_DATA_H     47
`define CMD_DATA_L     16
`define CMD_ADDR_H     15
`define CMD_ADDR_L     0

`endif

// ==== verilog/sequencer_pkg.sv ====
package sequencer_pkg;

  // system time and command execution time
  typedef logic [31:0] time_t;

  // command bus address
  // bits 15:8 select the unit, bits 1:0 carry the operation
  typedef logic [15:0] bus_addr_t;

  // command bus data word
  typedef logic [31:0] bus_data_t;

  // one packed command as stored in the command FIFO
  typedef logic [79:0] cmd_word_t;

  // scheduler states, one-hot
  typedef enum logic [3:0] {
    FETCH     = 4'b0001,
    FIFO_WAIT = 4'b0010,
    EXEC      = 4'b0100,
    EXEC_WAIT = 4'b1000
  } sched_state_t;

  // pin control operations in address bits 1:0
  typedef enum logic [1:0] {
    PIN_WRITE  = 2'd0,
    PIN_SET    = 2'd1,
    PIN_CLEAR  = 2'd2,
    PIN_TOGGLE = 2'd3
  } pin_op_t;

endpackage

// ==== verilog/event_timer.sv ====
`timescale 1ns/100ps

`include "sequencer_cfg.svh"

module event_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 timer_start,
  input  logic                 timer_clear,
  output sequencer_pkg::time_t current_time
);

  // prescaler width, at least one bit
  localparam int DIV_W = (`TIME_TICK_DIV > 1) ? $clog2(`TIME_TICK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`TIME_TICK_DIV - 1);

  logic             running;
  logic [DIV_W-1:0] prescale;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      running      <= 1'b0;
      prescale     <= '0;
      current_time <= '0;
    end else if (timer_clear) begin
      // clear wins over start and stops the timer
      running      <= 1'b0;
      prescale     <= '0;
      current_time <= '0;
    end else begin
      if (timer_start) begin
        running <= 1'b1;
      end
      if (running) begin
        // one time unit per TIME_TICK_DIV clocks
        if (prescale == DIV_LAST) begin
          prescale     <= '0;
          current_time <= current_time + 1'b1;
        end else begin
          prescale <= prescale + 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/cmd_fifo.sv ====
`timescale 1ns/100ps

`include "sequencer_cfg.svh"

module cmd_fifo (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  sequencer_pkg::cmd_word_t wr_data,
  input  logic                     rd_en,
  output sequencer_pkg::cmd_word_t rd_data,
  output logic                     rd_valid,
  output logic                     empty,
  output logic                     full
);

  import sequencer_pkg::*;

  localparam int AW = `CMD_FIFO_AW;

  cmd_word_t     mem [`CMD_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // one extra bit so a full buffer is distinct from an empty one
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  // writes while full are dropped, reads while empty are ignored
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // flags follow the count, so they change on the edge of the access
  assign empty = (count == '0);
  assign full  = (count == (AW+1)'(`CMD_FIFO_DEPTH));

  // storage and read register
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // pointers, occupancy and the valid pulse
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_rd;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves the count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the scheduler only reads when it sees data
  a_no_rd_when_empty: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> !empty
  );

  // data is handed back exactly one cycle after the request
  a_valid_after_rd: assert property (
    @(posedge clk) disable iff (rst) rd_en |=> rd_valid
  );

endmodule

// ==== verilog/command_scheduler.sv ====
`timescale 1ns/100ps

`include "sequencer_cfg.svh"

module command_scheduler (
  input  logic                     clk,
  input  logic                     rst,
  input  sequencer_pkg::time_t     current_time,
  input  sequencer_pkg::cmd_word_t cmd_dout,
  input  logic                     cmd_empty,
  input  logic                     cmd_valid,
  output logic                     cmd_rd_en,
  output sequencer_pkg::bus_addr_t cmd_bus_addr,
  output sequencer_pkg::bus_data_t cmd_bus_data,
  output logic                     cmd_bus_en,
  output logic                     cmd_bus_wr
);

  import sequencer_pkg::*;

  sched_state_t state;
  sched_state_t next_state;
  cmd_word_t    command;
  time_t        cmd_time;
  logic         write_cmd_reg;
  logic         time_reached;

  // time field of the held command
  assign cmd_time = command[`CMD_TIME_H:`CMD_TIME_L];

  // time 0 means run now, whatever the system time is
  assign time_reached = (cmd_time == '0) || (current_time >= cmd_time);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= FETCH;
    end else begin
      state <= next_state;
    end
  end

  // next state and control outputs
  // outputs are combinational, straight from the state
  always_comb begin
    next_state    = state;
    cmd_rd_en     = 1'b0;
    cmd_bus_en    = 1'b0;
    cmd_bus_wr    = 1'b0;
    write_cmd_reg = 1'b0;
    case (state)
      FETCH: begin
        // ask the FIFO for a word as soon as one is there
        if (!cmd_empty) begin
          cmd_rd_en  = 1'b1;
          next_state = FIFO_WAIT;
        end
      end
      FIFO_WAIT: begin
        // word arrives one cycle after the read
        if (cmd_valid) begin
          write_cmd_reg = 1'b1;
          next_state    = EXEC;
        end
      end
      EXEC: begin
        // hold here until the command is due
        if (time_reached) begin
          cmd_bus_en = 1'b1;
          cmd_bus_wr = 1'b1;
          next_state = EXEC_WAIT;
        end
      end
      EXEC_WAIT: begin
        // bus lines stay stable one more cycle for the units
        next_state = FETCH;
      end
      default: begin
        next_state = FETCH;
      end
    endcase
  end

  // held command register, payload only
  always_ff @(posedge clk) begin
    if (write_cmd_reg) begin
      command <= cmd_dout;
    end
  end

  // bus address and data come straight from the held command
  assign cmd_bus_addr = command[`CMD_ADDR_H:`CMD_ADDR_L];
  assign cmd_bus_data = command[`CMD_DATA_H:`CMD_DATA_L];

  // one strobe per command, never two in a row
  a_bus_en_single: assert property (
    @(posedge clk) disable iff (rst) cmd_bus_en |=> !cmd_bus_en
  );

  // enable and write always travel together on this bus
  a_bus_en_with_wr: assert property (
    @(posedge clk) disable iff (rst) cmd_bus_en |-> cmd_bus_wr
  );

  // a read is followed by the wait for FIFO data
  a_rd_only_in_fetch: assert property (
    @(posedge clk) disable iff (rst)
      cmd_rd_en |-> (state == FETCH) ##1 (state == FIFO_WAIT)
  );

endmodule

// ==== verilog/pin_control.sv ====
`timescale 1ns/100ps

`include "sequencer_cfg.svh"

module pin_control (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     bus_en,
  input  logic                     bus_wr,
  input  sequencer_pkg::bus_addr_t bus_addr,
  input  sequencer_pkg::bus_data_t bus_data,
  output sequencer_pkg::bus_data_t pin_state
);

  import sequencer_pkg::*;

  logic      unit_hit;
  logic      bus_write;
  pin_op_t   op;
  bus_data_t pin_next;

  // upper address byte selects the unit
  assign unit_hit = (bus_addr[15:8] == `PIN_UNIT_ID);

  // a write strobe that is meant for this unit
  assign bus_write = bus_en && bus_wr && unit_hit;

  // operation in the two low address bits
  // bits 7:2 carry nothing for this unit
  assign op = pin_op_t'(bus_addr[1:0]);

  // new pin value for each operation
  always_comb begin
    case (op)
      PIN_WRITE: begin
        // whole register replaced
        pin_next = bus_data;
      end
      PIN_SET: begin
        // ones in data drive pins high
        pin_next = pin_state | bus_data;
      end
      PIN_CLEAR: begin
        // ones in data drive pins low
        pin_next = pin_state & ~bus_data;
      end
      PIN_TOGGLE: begin
        // ones in data flip pins
        pin_next = pin_state ^ bus_data;
      end
      default: begin
        pin_next = pin_state;
      end
    endcase
  end

  // pin register
  // updates on the edge that sees the bus strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pin_state <= '0;
    end else if (bus_write) begin
      pin_state <= pin_next;
    end
  end

endmodule

// ==== verilog/sequencer_top.sv ====
`timescale 1ns/100ps

module sequencer_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     timer_start,
  input  logic                     timer_clear,
  input  logic                     cmd_wr_en,
  input  sequencer_pkg::cmd_word_t cmd_wr_data,
  output logic                     cmd_full,
  output sequencer_pkg::time_t     current_time,
  output sequencer_pkg::bus_addr_t cmd_bus_addr,
  output sequencer_pkg::bus_data_t cmd_bus_data,
  output logic                     cmd_bus_en,
  output logic                     cmd_bus_wr,
  output sequencer_pkg::bus_data_t pin_state
);

  import sequencer_pkg::*;

  // FIFO to scheduler
  cmd_word_t cmd_dout;
  logic      cmd_rd_en;
  logic      cmd_valid;
  logic      cmd_empty;

  // system time for the scheduler, also visible outside
  event_timer event_timer_inst (
    .clk          (clk),
    .rst          (rst),
    .timer_start  (timer_start),
    .timer_clear  (timer_clear),
    .current_time (current_time)
  );

  // host side command buffer
  cmd_fifo cmd_fifo_inst (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (cmd_wr_en),
    .wr_data  (cmd_wr_data),
    .rd_en    (cmd_rd_en),
    .rd_data  (cmd_dout),
    .rd_valid (cmd_valid),
    .empty    (cmd_empty),
    .full     (cmd_full)
  );

  // releases each command on the bus at its time
  command_scheduler command_scheduler_inst (
    .clk          (clk),
    .rst          (rst),
    .current_time (current_time),
    .cmd_dout     (cmd_dout),
    .cmd_empty    (cmd_empty),
    .cmd_valid    (cmd_valid),
    .cmd_rd_en    (cmd_rd_en),
    .cmd_bus_addr (cmd_bus_addr),
    .cmd_bus_data (cmd_bus_data),
    .cmd_bus_en   (cmd_bus_en),
    .cmd_bus_wr   (cmd_bus_wr)
  );

  // one bus slave here, other units hang off the top level bus
  pin_control pin_control_inst (
    .clk       (clk),
    .rst       (rst),
    .bus_en    (cmd_bus_en),
    .bus_wr    (cmd_bus_wr),
    .bus_addr  (cmd_bus_addr),
    .bus_data  (cmd_bus_data),
    .pin_state (pin_state)
  );

endmodule

// ==== verification/sequencer_tb.sv ====
`timescale 1ns/100ps

`include "sequencer_cfg.svh"

module sequencer_tb;

  import sequencer_pkg::*;

  logic      clk = 1'b0;
  logic      rst;
  logic      timer_start;
  logic      timer_clear;
  logic      cmd_wr_en;
  cmd_word_t cmd_wr_data;
  logic      cmd_full;
  time_t     current_time;
  bus_addr_t cmd_bus_addr;
  bus_data_t cmd_bus_data;
  logic      cmd_bus_en;
  logic      cmd_bus_wr;
  bus_data_t pin_state;

  // commands written but not yet seen on the bus, oldest first
  cmd_word_t   exp_q[$];
  bus_data_t   model_pins;
  logic [31:0] lfsr_state;
  time_t       last_pulse_time;
  string       cur_test;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  int          pulse_count;
  bit          timed_out;

  sequencer_top sequencer_top_inst (
    .clk          (clk),
    .rst          (rst),
    .timer_start  (timer_start),
    .timer_clear  (timer_clear),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_wr_data  (cmd_wr_data),
    .cmd_full     (cmd_full),
    .current_time (current_time),
    .cmd_bus_addr (cmd_bus_addr),
    .cmd_bus_data (cmd_bus_data),
    .cmd_bus_en   (cmd_bus_en),
    .cmd_bus_wr   (cmd_bus_wr),
    .pin_state    (pin_state)
  );

  // 20 ns clock
  initial begin
    forever #10 clk = ~clk;
  end

  // galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // expected pin register after one bus write
  // foreign unit ids leave the pins alone
  function automatic bus_data_t apply_pin_op(input bus_data_t pins, input bus_addr_t addr,
                                             input bus_data_t data);
    pin_op_t   op;
    bus_data_t result;
    op = pin_op_t'(addr[1:0]);
    result = pins;
    if (addr[15:8] == `PIN_UNIT_ID) begin
      case (op)
        PIN_WRITE:  result = data;
        PIN_SET:    result = pins | data;
        PIN_CLEAR:  result = pins & ~data;
        PIN_TOGGLE: result = pins ^ data;
        default:    result = pins;
      endcase
    end
    return result;
  endfunction

  // pack one command, address bits 7:2 get random filler
  function automatic cmd_word_t make_cmd(input time_t t, input logic [7:0] unit,
                                         input pin_op_t op, input bus_data_t data);
    cmd_word_t   w;
    logic [31:0] filler;
    filler = rand_bits(6);
    w = '0;
    w[`CMD_TIME_H:`CMD_TIME_L] = t;
    w[`CMD_DATA_H:`CMD_DATA_L] = data;
    w[`CMD_ADDR_H:`CMD_ADDR_L] = {unit, filler[5:0], op};
    return w;
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // host write, one cycle of cmd_wr_en, model follows the same order
  task automatic queue_cmd(input cmd_word_t w);
    exp_q.push_back(w);
    model_pins = apply_pin_op(model_pins, w[`CMD_ADDR_H:`CMD_ADDR_L],
                              w[`CMD_DATA_H:`CMD_DATA_L]);
    @(posedge clk);
    cmd_wr_en   <= 1'b1;
    cmd_wr_data <= w;
    @(posedge clk);
    cmd_wr_en   <= 1'b0;
  endtask

  // clear zeroes and stops the timer
  task automatic clear_timer();
    @(posedge clk);
    timer_clear <= 1'b1;
    @(posedge clk);
    timer_clear <= 1'b0;
    last_pulse_time = '0;
  endtask

  task automatic start_timer();
    @(posedge clk);
    timer_start <= 1'b1;
    @(posedge clk);
    timer_start <= 1'b0;
  endtask

  // wait until every queued command has reached the bus
  task automatic wait_drain(input string what, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (exp_q.size() != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() == 0) begin
      ok = 1'b1;
      // pin register settles on the edge after the last strobe
      @(negedge clk);
    end else begin
      $display("timeout in %s: %0d commands still pending after %0d cycles",
               what, exp_q.size(), cycles);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  // bus monitor, strobes are stable at the falling edge
  initial begin : bus_monitor
    cmd_word_t exp_cmd;
    time_t     exp_time;
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && cmd_bus_en === 1'b1) begin
        pulse_count++;
        check_value(cur_test, "bus write strobe", 32'd1, 32'(cmd_bus_wr));
        check_value(cur_test, "time not decreasing", 32'd1,
                    32'(current_time >= last_pulse_time));
        last_pulse_time = current_time;
        if (exp_q.size() == 0) begin
          $display("bus strobe at address %h with no command pending", cmd_bus_addr);
          error_count++;
        end else begin
          exp_cmd  = exp_q.pop_front();
          exp_time = exp_cmd[`CMD_TIME_H:`CMD_TIME_L];
          check_value(cur_test, "bus address", 32'(exp_cmd[`CMD_ADDR_H:`CMD_ADDR_L]),
                      32'(cmd_bus_addr));
          check_value(cur_test, "bus data", exp_cmd[`CMD_DATA_H:`CMD_DATA_L], cmd_bus_data);
          // time 0 runs at once
          if (exp_time != '0) begin
            check_value(cur_test, "release time reached", 32'd1,
                        32'(current_time >= exp_time));
          end
        end
      end
    end
  end

  task automatic test_reset_state();
    int errs;
    errs = error_count;
    cur_test = "reset_state";
    check_value(cur_test, "pin_state", 32'd0, pin_state);
    check_value(cur_test, "current_time", 32'd0, current_time);
    check_value(cur_test, "cmd_bus_en", 32'd0, 32'(cmd_bus_en));
    check_value(cur_test, "cmd_full", 32'd0, 32'(cmd_full));
    end_test(cur_test, errs);
  endtask

  task automatic test_immediate();
    int errs;
    bit ok;
    errs = error_count;
    cur_test = "immediate_cmds";
    for (int i = 0; i < 20; i++) begin
      queue_cmd(make_cmd('0, `PIN_UNIT_ID, pin_op_t'(rand_bits(2)), rand_bits(32)));
    end
    wait_drain(cur_test, 400, ok);
    if (ok) begin
      check_value(cur_test, "pin_state", model_pins, pin_state);
    end
    end_test(cur_test, errs);
  endtask

  task automatic test_timed();
    int    errs;
    bit    ok;
    time_t t;
    errs = error_count;
    cur_test = "timed_release";
    clear_timer();
    start_timer();
    t = 32'd4;
    // rising execution times, random gaps
    for (int i = 0; i < 10; i++) begin
      queue_cmd(make_cmd(t, `PIN_UNIT_ID, pin_op_t'(rand_bits(2)), rand_bits(32)));
      t = t + 32'd3 + rand_bits(3);
    end
    wait_drain(cur_test, 2000, ok);
    if (ok) begin
      check_value(cur_test, "pin_state", model_pins, pin_state);
    end
    end_test(cur_test, errs);
  endtask

  task automatic test_foreign();
    int          errs;
    bit          ok;
    bus_data_t   pins_before;
    logic [31:0] unit;
    errs = error_count;
    cur_test = "foreign_units";
    pins_before = model_pins;
    for (int i = 0; i < 8; i++) begin
      unit = rand_bits(8);
      if (unit[7:0] == `PIN_UNIT_ID) begin
        unit[7] = ~unit[7];
      end
      queue_cmd(make_cmd('0, unit[7:0], pin_op_t'(rand_bits(2)), rand_bits(32)));
    end
    wait_drain(cur_test, 400, ok);
    if (ok) begin
      check_value(cur_test, "pin_state", model_pins, pin_state);
      check_value(cur_test, "pins unchanged", pins_before, pin_state);
    end
    end_test(cur_test, errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    int pulses_before;
    bit ok;
    errs = error_count;
    cur_test = "back_pressure";
    // timer stays stopped at 0, so this command blocks the scheduler
    clear_timer();
    queue_cmd(make_cmd(32'd1000, `PIN_UNIT_ID, pin_op_t'(rand_bits(2)), rand_bits(32)));
    repeat (8) @(posedge clk);
    pulses_before = pulse_count;
    for (int i = 0; i < 16; i++) begin
      queue_cmd(make_cmd('0, `PIN_UNIT_ID, pin_op_t'(rand_bits(2)), rand_bits(32)));
      @(negedge clk);
      check_value(cur_test, "cmd_full", (i == 15) ? 32'd1 : 32'd0, 32'(cmd_full));
    end
    check_value(cur_test, "bus strobes while stalled", 32'(pulses_before), 32'(pulse_count));
    start_timer();
    wait_drain(cur_test, 6000, ok);
    if (ok) begin
      check_value(cur_test, "pin_state", model_pins, pin_state);
    end
    end_test(cur_test, errs);
  endtask

  initial begin
    rst          = 1'b1;
    timer_start  = 1'b0;
    timer_clear  = 1'b0;
    cmd_wr_en    = 1'b0;
    cmd_wr_data  = '0;
    lfsr_state   = 32'h926e;
    model_pins   = '0;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    pulse_count  = 0;
    timed_out    = 1'b0;
    last_pulse_time = '0;
    cur_test     = "reset";
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_reset_state();
    if (!timed_out) test_immediate();
    if (!timed_out) test_timed();
    if (!timed_out) test_foreign();
    if (!timed_out) test_back_pressure();
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/sequencer_pkg.sv
verilog/event_timer.sv
verilog/cmd_fifo.sv
verilog/command_scheduler.sv
verilog/pin_control.sv
verilog/sequencer_top.sv
verification/sequencer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sequencer testbench with Verilator
# the run counts as passed only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module sequencer_tb -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 ||
echo "simulation failed" && exit 1
